//--- Bender.yml
package:
  name: hci_queues

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/hci_pkg.sv
      - rtl/hci_sync_fifo.sv
      - rtl/hci_cmd_assembler.sv
      - rtl/hci_csr_ctrl.sv
      - rtl/hci_queues_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/hci_queues_checker.sv
      - verif/tb_hci_queues.sv

//--- flist.f
+incdir+include
rtl/hci_pkg.sv
rtl/hci_sync_fifo.sv
rtl/hci_cmd_assembler.sv
rtl/hci_csr_ctrl.sv
rtl/hci_queues_top.sv
verif/hci_queues_checker.sv
verif/tb_hci_queues.sv

//--- include/hci_config.svh
// CSR map, field positions and queue sizes; CSR addresses are byte addresses on a 32-bit word port
`ifndef HCI_CONFIG_SVH
`define HCI_CONFIG_SVH

`define HCI_CSR_ADDR_W  5
`define HCI_CSR_DATA_W  32
`define HCI_CMD_DESC_W  64
`define HCI_RESP_DESC_W 32

`define HCI_CMD_DEPTH   8
`define HCI_RESP_DEPTH  8
`define HCI_THLD_W      8
`define HCI_THLD_RESET  1

// Word-aligned register offsets
`define HCI_ADDR_CMD_PORT    5'h00
`define HCI_ADDR_RESP_PORT   5'h04
`define HCI_ADDR_THLD_CTRL   5'h08
`define HCI_ADDR_QUEUE_STAT  5'h0C
`define HCI_ADDR_RESET_CTRL  5'h10

`define HCI_THLD_CMD_LSB        0
`define HCI_THLD_RESP_LSB       8
`define HCI_STAT_CMD_DEPTH_LSB  0
`define HCI_STAT_RESP_DEPTH_LSB 8
`define HCI_STAT_CMD_EMPTY      16
`define HCI_STAT_CMD_FULL       17
`define HCI_STAT_RESP_EMPTY     18
`define HCI_STAT_RESP_FULL      19
`define HCI_RST_CMD_QUEUE       1
`define HCI_RST_RESP_QUEUE      2

`endif

//--- rtl/hci_cmd_assembler.sv
// Low word arrives first; a second word that meets a full command FIFO is dropped with its pair
`timescale 1ns/1ps
`include "hci_config.svh"

module hci_cmd_assembler (
  input  logic                hclk_i,
  input  logic                rst_n_i,
  input  logic                word_wr_i,
  input  hci_pkg::csr_data_t  word_i,
  input  logic                flush_i,
  input  logic                fifo_full_i,
  output logic                push_o,
  output hci_pkg::cmd_desc_t  desc_o,
  output logic                drop_o
);

  hci_pkg::csr_data_t low_q;
  logic               hi_next_q;
  logic               hi_word;

  // Second word of the pair completes the descriptor
  assign hi_word = word_wr_i & hi_next_q;

  always_ff @(posedge hclk_i) begin
    if (!rst_n_i) begin
      hi_next_q <= 1'b0;
    end else if (flush_i) begin
      hi_next_q <= 1'b0;
    end else if (word_wr_i) begin
      // Toggles on every word, also when the pair is dropped
      hi_next_q <= ~hi_next_q;
    end
  end

  always_ff @(posedge hclk_i) begin
    if (word_wr_i && !hi_next_q) begin
      low_q <= word_i;
    end
  end

  // Descriptor goes straight into the FIFO in the same cycle
  assign desc_o = {word_i, low_q};
  assign push_o = hi_word & ~fifo_full_i;
  assign drop_o = hi_word & fifo_full_i;

endmodule

//--- rtl/hci_csr_ctrl.sv
// One request in flight; every ack comes exactly one cycle after its request and RESET_CTRL reads 0
`timescale 1ns/1ps
`include "hci_config.svh"

module hci_csr_ctrl (
  input  logic                 hclk_i,
  input  logic                 rst_n_i,
  input  logic                 csr_req_i,
  input  logic                 csr_req_is_wr_i,
  input  hci_pkg::csr_addr_t   csr_addr_i,
  input  hci_pkg::csr_data_t   csr_wr_data_i,
  output logic                 csr_rd_ack_o,
  output logic                 csr_rd_err_o,
  output hci_pkg::csr_data_t   csr_rd_data_o,
  output logic                 csr_wr_ack_o,
  output logic                 csr_wr_err_o,
  input  logic                 cmd_drop_i,
  input  hci_pkg::cmd_depth_t  cmd_depth_i,
  input  logic                 cmd_empty_i,
  input  logic                 cmd_full_i,
  input  hci_pkg::resp_desc_t  resp_rdata_i,
  input  hci_pkg::resp_depth_t resp_depth_i,
  input  logic                 resp_empty_i,
  input  logic                 resp_full_i,
  output logic                 cmd_word_wr_o,
  output hci_pkg::csr_data_t   cmd_word_o,
  output logic                 resp_pop_o,
  output logic                 cmd_flush_o,
  output logic                 resp_flush_o,
  output logic                 cmd_thld_trig_o,
  output logic                 resp_thld_trig_o
);

  logic               rd_req;
  logic               wr_req;
  logic               rd_err_d;
  logic               wr_err_d;
  hci_pkg::csr_data_t rd_data_d;
  hci_pkg::thld_t     cmd_thld_q;
  hci_pkg::thld_t     resp_thld_q;
  logic               thld_we;
  logic               rst_we;

  assign rd_req  = csr_req_i & ~csr_req_is_wr_i;
  assign wr_req  = csr_req_i & csr_req_is_wr_i;
  assign thld_we = wr_req & (csr_addr_i == `HCI_ADDR_THLD_CTRL);
  assign rst_we  = wr_req & (csr_addr_i == `HCI_ADDR_RESET_CTRL);

  // Queue side strobes act in the request cycle
  assign cmd_word_wr_o = wr_req & (csr_addr_i == `HCI_ADDR_CMD_PORT);
  assign cmd_word_o    = csr_wr_data_i;
  assign resp_pop_o    = rd_req & (csr_addr_i == `HCI_ADDR_RESP_PORT) & ~resp_empty_i;

  // Read decode
  always_comb begin
    rd_data_d = '0;
    rd_err_d  = 1'b0;
    case (csr_addr_i)
      `HCI_ADDR_RESP_PORT: begin
        if (resp_empty_i) begin
          rd_err_d = 1'b1;
        end else begin
          rd_data_d = resp_rdata_i;
        end
      end
      `HCI_ADDR_THLD_CTRL: begin
        rd_data_d[`HCI_THLD_CMD_LSB +: `HCI_THLD_W]  = cmd_thld_q;
        rd_data_d[`HCI_THLD_RESP_LSB +: `HCI_THLD_W] = resp_thld_q;
      end
      `HCI_ADDR_QUEUE_STAT: begin
        rd_data_d[`HCI_STAT_CMD_DEPTH_LSB +: $bits(cmd_depth_i)]   = cmd_depth_i;
        rd_data_d[`HCI_STAT_RESP_DEPTH_LSB +: $bits(resp_depth_i)] = resp_depth_i;
        rd_data_d[`HCI_STAT_CMD_EMPTY]  = cmd_empty_i;
        rd_data_d[`HCI_STAT_CMD_FULL]   = cmd_full_i;
        rd_data_d[`HCI_STAT_RESP_EMPTY] = resp_empty_i;
        rd_data_d[`HCI_STAT_RESP_FULL]  = resp_full_i;
      end
      `HCI_ADDR_RESET_CTRL: rd_data_d = '0;
      default: rd_err_d = 1'b1;
    endcase
  end

  // Write decode; a dropped descriptor fails its second word
  always_comb begin
    case (csr_addr_i)
      `HCI_ADDR_CMD_PORT:   wr_err_d = cmd_drop_i;
      `HCI_ADDR_THLD_CTRL:  wr_err_d = 1'b0;
      `HCI_ADDR_RESET_CTRL: wr_err_d = 1'b0;
      default:              wr_err_d = 1'b1;
    endcase
  end

  always_ff @(posedge hclk_i) begin
    if (!rst_n_i) begin
      csr_rd_ack_o <= 1'b0;
      csr_rd_err_o <= 1'b0;
      csr_wr_ack_o <= 1'b0;
      csr_wr_err_o <= 1'b0;
      cmd_thld_q   <= hci_pkg::thld_t'(`HCI_THLD_RESET);
      resp_thld_q  <= hci_pkg::thld_t'(`HCI_THLD_RESET);
      cmd_flush_o  <= 1'b0;
      resp_flush_o <= 1'b0;
    end else begin
      csr_rd_ack_o <= rd_req;
      csr_rd_err_o <= rd_req & rd_err_d;
      csr_wr_ack_o <= wr_req;
      csr_wr_err_o <= wr_req & wr_err_d;
      if (thld_we) begin
        cmd_thld_q  <= csr_wr_data_i[`HCI_THLD_CMD_LSB +: `HCI_THLD_W];
        resp_thld_q <= csr_wr_data_i[`HCI_THLD_RESP_LSB +: `HCI_THLD_W];
      end
      // Self-clearing, high only during the ack cycle
      cmd_flush_o  <= rst_we & csr_wr_data_i[`HCI_RST_CMD_QUEUE];
      resp_flush_o <= rst_we & csr_wr_data_i[`HCI_RST_RESP_QUEUE];
    end
  end

  always_ff @(posedge hclk_i) begin
    if (rd_req) begin
      csr_rd_data_o <= rd_data_d;
    end
  end

  // Zero threshold disables the trigger
  assign cmd_thld_trig_o  = (cmd_thld_q != '0) &&
                            (hci_pkg::thld_t'(cmd_depth_i) >= cmd_thld_q);
  assign resp_thld_trig_o = (resp_thld_q != '0) &&
                            (hci_pkg::thld_t'(resp_depth_i) >= resp_thld_q);

endmodule

//--- rtl/hci_pkg.sv
// Shared types for the queue block; all widths derive from the config header macros
`include "hci_config.svh"

package hci_pkg;

  // CSR port
  typedef logic [`HCI_CSR_ADDR_W-1:0] csr_addr_t;
  typedef logic [`HCI_CSR_DATA_W-1:0] csr_data_t;

  // Command descriptor is sent as two CSR words, low word first
  typedef logic [`HCI_CMD_DESC_W-1:0] cmd_desc_t;

  // Response descriptor fits one CSR word
  typedef logic [`HCI_RESP_DESC_W-1:0] resp_desc_t;

  // Ready threshold, zero disables the trigger
  typedef logic [`HCI_THLD_W-1:0] thld_t;

  // Occupancy counts, wide enough to hold a full queue
  typedef logic [$clog2(`HCI_CMD_DEPTH + 1)-1:0] cmd_depth_t;
  typedef logic [$clog2(`HCI_RESP_DEPTH + 1)-1:0] resp_depth_t;

endpackage

//--- rtl/hci_queues_top.sv
// Command queue feeds the controller FSM and the response queue returns to the host over CSR
`timescale 1ns/1ps
`include "hci_config.svh"

module hci_queues_top (
  input  logic                 hclk_i,
  input  logic                 rst_n_i,
  input  logic                 csr_req_i,
  input  logic                 csr_req_is_wr_i,
  input  hci_pkg::csr_addr_t   csr_addr_i,
  input  hci_pkg::csr_data_t   csr_wr_data_i,
  output logic                 csr_rd_ack_o,
  output logic                 csr_rd_err_o,
  output hci_pkg::csr_data_t   csr_rd_data_o,
  output logic                 csr_wr_ack_o,
  output logic                 csr_wr_err_o,
  output logic                 cmd_rvalid_o,
  input  logic                 cmd_rready_i,
  output hci_pkg::cmd_desc_t   cmd_rdata_o,
  output hci_pkg::cmd_depth_t  cmd_depth_o,
  output logic                 cmd_empty_o,
  output logic                 cmd_full_o,
  output logic                 cmd_thld_trig_o,
  input  logic                 resp_wvalid_i,
  output logic                 resp_wready_o,
  input  hci_pkg::resp_desc_t  resp_wdata_i,
  output hci_pkg::resp_depth_t resp_depth_o,
  output logic                 resp_empty_o,
  output logic                 resp_full_o,
  output logic                 resp_thld_trig_o
);

  logic                cmd_word_wr;
  hci_pkg::csr_data_t  cmd_word;
  logic                cmd_push;
  hci_pkg::cmd_desc_t  cmd_desc;
  logic                cmd_drop;
  logic                cmd_flush;
  logic                resp_pop;
  logic                resp_flush;
  hci_pkg::resp_desc_t resp_rdata;

  assign cmd_rvalid_o  = ~cmd_empty_o;
  assign resp_wready_o = ~resp_full_o;

  hci_csr_ctrl u_csr_ctrl (
    .hclk_i, .rst_n_i,
    .csr_req_i, .csr_req_is_wr_i, .csr_addr_i, .csr_wr_data_i,
    .csr_rd_ack_o, .csr_rd_err_o, .csr_rd_data_o, .csr_wr_ack_o, .csr_wr_err_o,
    .cmd_drop_i(cmd_drop), .cmd_depth_i(cmd_depth_o),
    .cmd_empty_i(cmd_empty_o), .cmd_full_i(cmd_full_o),
    .resp_rdata_i(resp_rdata), .resp_depth_i(resp_depth_o),
    .resp_empty_i(resp_empty_o), .resp_full_i(resp_full_o),
    .cmd_word_wr_o(cmd_word_wr), .cmd_word_o(cmd_word), .resp_pop_o(resp_pop),
    .cmd_flush_o(cmd_flush), .resp_flush_o(resp_flush),
    .cmd_thld_trig_o, .resp_thld_trig_o
  );

  hci_cmd_assembler u_cmd_assembler (
    .hclk_i, .rst_n_i,
    .word_wr_i(cmd_word_wr), .word_i(cmd_word), .flush_i(cmd_flush),
    .fifo_full_i(cmd_full_o), .push_o(cmd_push), .desc_o(cmd_desc), .drop_o(cmd_drop)
  );

  hci_sync_fifo #(.Depth(`HCI_CMD_DEPTH), .Width(`HCI_CMD_DESC_W)) cmd_fifo (
    .hclk_i, .rst_n_i,
    .flush_i(cmd_flush), .push_i(cmd_push), .wdata_i(cmd_desc),
    .pop_i(cmd_rvalid_o & cmd_rready_i), .rdata_o(cmd_rdata_o),
    .depth_o(cmd_depth_o), .empty_o(cmd_empty_o), .full_o(cmd_full_o)
  );

  hci_sync_fifo #(.Depth(`HCI_RESP_DEPTH), .Width(`HCI_RESP_DESC_W)) resp_fifo (
    .hclk_i, .rst_n_i,
    .flush_i(resp_flush), .push_i(resp_wvalid_i & resp_wready_o), .wdata_i(resp_wdata_i),
    .pop_i(resp_pop), .rdata_o(resp_rdata),
    .depth_o(resp_depth_o), .empty_o(resp_empty_o), .full_o(resp_full_o)
  );

endmodule

//--- rtl/hci_sync_fifo.sv
// Single-clock show-ahead FIFO; a push while full or a pop while empty is dropped and flush wins
`timescale 1ns/1ps
`include "hci_config.svh"

module hci_sync_fifo #(
  parameter int unsigned Depth = `HCI_CMD_DEPTH,
  parameter int unsigned Width = `HCI_CSR_DATA_W,
  localparam int unsigned CntW = $clog2(Depth + 1),
  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1
) (
  input  logic             hclk_i,
  input  logic             rst_n_i,
  input  logic             flush_i,
  input  logic             push_i,
  input  logic [Width-1:0] wdata_i,
  input  logic             pop_i,
  output logic [Width-1:0] rdata_o,
  output logic [CntW-1:0]  depth_o,
  output logic             empty_o,
  output logic             full_o
);

  logic [Width-1:0] mem_q [Depth];
  logic [PtrW-1:0]  rd_ptr_q;
  logic [PtrW-1:0]  wr_ptr_q;
  logic [CntW-1:0]  count_q;
  logic             do_push;
  logic             do_pop;

  // Wraps at Depth so non power of two sizes work
  function automatic logic [PtrW-1:0] ptr_inc(input logic [PtrW-1:0] ptr);
    logic [PtrW-1:0] next;
    if (ptr == PtrW'(Depth - 1)) begin
      next = '0;
    end else begin
      next = ptr + 1'b1;
    end
    return next;
  endfunction

  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  always_ff @(posedge hclk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= wdata_i;
    end
  end

  always_ff @(posedge hclk_i) begin
    if (!rst_n_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Head entry is visible without a pop
  assign rdata_o = mem_q[rd_ptr_q];
  assign depth_o = count_q;
  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == CntW'(Depth));

endmodule

//--- verif/hci_queues_checker.sv
// Handshake and status rules of hci_queues_top; assumes one CSR request in flight at a time
`timescale 1ns/1ps
`include "hci_config.svh"

module hci_queues_checker (
  input logic                 hclk_i,
  input logic                 rst_n_i,
  input logic                 csr_req_i,
  input logic                 csr_req_is_wr_i,
  input logic                 csr_rd_ack_o,
  input logic                 csr_rd_err_o,
  input hci_pkg::csr_data_t   csr_rd_data_o,
  input logic                 csr_wr_ack_o,
  input hci_pkg::cmd_depth_t  cmd_depth_o,
  input hci_pkg::resp_depth_t resp_depth_o
);

  int unsigned fail_count = 0;

  rd_ack_next: assert property (@(posedge hclk_i) disable iff (!rst_n_i)
    csr_req_i && !csr_req_is_wr_i |=> csr_rd_ack_o && !csr_wr_ack_o)
    else begin
      $error("read request not acknowledged in the next cycle");
      fail_count++;
    end

  wr_ack_next: assert property (@(posedge hclk_i) disable iff (!rst_n_i)
    csr_req_i && csr_req_is_wr_i |=> csr_wr_ack_o && !csr_rd_ack_o)
    else begin
      $error("write request not acknowledged in the next cycle");
      fail_count++;
    end

  // Failed reads return zero data
  rd_err_zero: assert property (@(posedge hclk_i) disable iff (!rst_n_i)
    csr_rd_err_o |-> (csr_rd_data_o == '0))
    else begin
      $error("read error returned nonzero data");
      fail_count++;
    end

  // Occupancy stays within depth and grows by at most one entry per edge
  cmd_depth_step: assert property (@(posedge hclk_i) disable iff (!rst_n_i)
    (cmd_depth_o <= `HCI_CMD_DEPTH) && (cmd_depth_o <= $past(cmd_depth_o) + 1'b1))
    else begin
      $error("command queue depth out of range or jumped");
      fail_count++;
    end

  resp_depth_step: assert property (@(posedge hclk_i) disable iff (!rst_n_i)
    (resp_depth_o <= `HCI_RESP_DEPTH) && (resp_depth_o <= $past(resp_depth_o) + 1'b1))
    else begin
      $error("response queue depth out of range or jumped");
      fail_count++;
    end

endmodule

//--- verif/tb_hci_queues.sv
// Controller inputs are held low during CSR accesses so every queue change is seen by the model
`timescale 1ns/1ps
`include "hci_config.svh"

module tb_hci_queues;

  localparam int NumOps = 300;
  localparam int StimCycles = 10 + NumOps * 8 + 300;
  localparam int TimeoutCycles = 4 * StimCycles;

  logic                 hclk_i;
  logic                 rst_n_i;
  logic                 csr_req_i;
  logic                 csr_req_is_wr_i;
  hci_pkg::csr_addr_t   csr_addr_i;
  hci_pkg::csr_data_t   csr_wr_data_i;
  logic                 csr_rd_ack_o;
  logic                 csr_rd_err_o;
  hci_pkg::csr_data_t   csr_rd_data_o;
  logic                 csr_wr_ack_o;
  logic                 csr_wr_err_o;
  logic                 cmd_rvalid_o;
  logic                 cmd_rready_i;
  hci_pkg::cmd_desc_t   cmd_rdata_o;
  hci_pkg::cmd_depth_t  cmd_depth_o;
  logic                 cmd_empty_o;
  logic                 cmd_full_o;
  logic                 cmd_thld_trig_o;
  logic                 resp_wvalid_i;
  logic                 resp_wready_o;
  hci_pkg::resp_desc_t  resp_wdata_i;
  hci_pkg::resp_depth_t resp_depth_o;
  logic                 resp_empty_o;
  logic                 resp_full_o;
  logic                 resp_thld_trig_o;

  // Reference model state
  hci_pkg::cmd_desc_t  cmd_q[$];
  hci_pkg::resp_desc_t resp_q[$];
  logic                half_pending;
  hci_pkg::csr_data_t  half_low;
  hci_pkg::thld_t      cmd_thld;
  hci_pkg::thld_t      resp_thld;
  logic [31:0]         lcg_state;
  int                  cycle_count = 0;

  hci_queues_top UUT (.*);

  bind hci_queues_top hci_queues_checker u_checker (.*);

  initial begin
    hclk_i = 1'b0;
    forever #2 hclk_i = ~hclk_i;
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic stop_with_failure();
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  always @(posedge hclk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TimeoutCycles) begin
      $display("Timeout: the run took longer than %0d cycles", TimeoutCycles);
      stop_with_failure();
    end
  end

  // Bound assertions count their failures
  always @(negedge hclk_i) begin
    if (UUT.u_checker.fail_count != 0) begin
      $display("A bound assertion on the DUT failed");
      stop_with_failure();
    end
  end

  task automatic check_cmd_desc(string what, hci_pkg::cmd_desc_t got, hci_pkg::cmd_desc_t exp);
    if (got !== exp) begin
      $display("Fail %0t: %s got %h expected %h", $time, what, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_resp_desc(string what, hci_pkg::resp_desc_t got,
                                 hci_pkg::resp_desc_t exp);
    if (got !== exp) begin
      $display("Fail %0t: %s got %h expected %h", $time, what, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_csr_data(string what, hci_pkg::csr_data_t got, hci_pkg::csr_data_t exp);
    if (got !== exp) begin
      $display("Fail %0t: %s got %h expected %h", $time, what, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_depth(string what, hci_pkg::cmd_depth_t got, hci_pkg::cmd_depth_t exp);
    if (got !== exp) begin
      $display("Fail %0t: %s got %0d expected %0d", $time, what, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_flag(string what, logic got, logic exp);
    if (got !== exp) begin
      $display("Fail %0t: %s got %b expected %b", $time, what, got, exp);
      stop_with_failure();
    end
  endtask

  // Compares every status output against the model, at the falling edge
  task automatic check_status();
    int nc;
    int nr;
    nc = cmd_q.size();
    nr = resp_q.size();
    check_flag("cmd_rvalid_o", cmd_rvalid_o, nc != 0);
    if (nc != 0) begin
      check_cmd_desc("cmd_rdata_o", cmd_rdata_o, cmd_q[0]);
    end
    check_depth("cmd_depth_o", cmd_depth_o, hci_pkg::cmd_depth_t'(nc));
    check_depth("resp_depth_o", resp_depth_o, hci_pkg::cmd_depth_t'(nr));
    check_flag("cmd_empty_o", cmd_empty_o, nc == 0);
    check_flag("cmd_full_o", cmd_full_o, nc == `HCI_CMD_DEPTH);
    check_flag("resp_wready_o", resp_wready_o, nr != `HCI_RESP_DEPTH);
    check_flag("resp_empty_o", resp_empty_o, nr == 0);
    check_flag("resp_full_o", resp_full_o, nr == `HCI_RESP_DEPTH);
    check_flag("cmd_thld_trig_o", cmd_thld_trig_o, (cmd_thld != 0) && (nc >= int'(cmd_thld)));
    check_flag("resp_thld_trig_o", resp_thld_trig_o,
               (resp_thld != 0) && (nr >= int'(resp_thld)));
  endtask

  task automatic csr_access(input logic wr, input hci_pkg::csr_addr_t addr,
                            input hci_pkg::csr_data_t wdata,
                            output hci_pkg::csr_data_t rdata, output logic err);
    int waited;
    waited = 0;
    @(posedge hclk_i);
    csr_req_i       <= 1'b1;
    csr_req_is_wr_i <= wr;
    csr_addr_i      <= addr;
    csr_wr_data_i   <= wdata;
    cmd_rready_i    <= 1'b0;
    resp_wvalid_i   <= 1'b0;
    @(posedge hclk_i);
    csr_req_i <= 1'b0;
    @(negedge hclk_i);
    while (!(wr ? csr_wr_ack_o : csr_rd_ack_o)) begin
      if (waited > 4) begin
        $display("No CSR acknowledge for address %h", addr);
        stop_with_failure();
      end
      waited++;
      @(negedge hclk_i);
    end
    rdata = csr_rd_data_o;
    err   = wr ? csr_wr_err_o : csr_rd_err_o;
  endtask

  task automatic write_cmd_word(hci_pkg::csr_data_t w);
    hci_pkg::csr_data_t d;
    logic e;
    logic exp_err;
    exp_err = half_pending && (cmd_q.size() == `HCI_CMD_DEPTH);
    csr_access(1'b1, `HCI_ADDR_CMD_PORT, w, d, e);
    check_flag("command write error", e, exp_err);
    if (!half_pending) begin
      half_low = w;
    end else if (!exp_err) begin
      cmd_q.push_back({w, half_low});
    end
    half_pending = ~half_pending;
    check_status();
  endtask

  task automatic read_resp();
    hci_pkg::csr_data_t d;
    logic e;
    csr_access(1'b0, `HCI_ADDR_RESP_PORT, '0, d, e);
    if (resp_q.size() == 0) begin
      check_flag("empty response read error", e, 1'b1);
      check_csr_data("empty response read data", d, '0);
    end else begin
      check_flag("response read error", e, 1'b0);
      check_resp_desc("response data", d, resp_q.pop_front());
    end
    check_status();
  endtask

  task automatic write_read_thld(hci_pkg::thld_t c, hci_pkg::thld_t r);
    hci_pkg::csr_data_t d;
    logic e;
    csr_access(1'b1, `HCI_ADDR_THLD_CTRL, {16'h0, r, c}, d, e);
    check_flag("threshold write error", e, 1'b0);
    cmd_thld  = c;
    resp_thld = r;
    csr_access(1'b0, `HCI_ADDR_THLD_CTRL, '0, d, e);
    check_flag("threshold read error", e, 1'b0);
    check_csr_data("threshold readback", d, {16'h0, resp_thld, cmd_thld});
    check_status();
  endtask

  task automatic read_stat();
    hci_pkg::csr_data_t d;
    hci_pkg::csr_data_t exp;
    logic e;
    exp = '0;
    exp[7:0]  = 8'(cmd_q.size());
    exp[15:8] = 8'(resp_q.size());
    exp[16]   = cmd_q.size() == 0;
    exp[17]   = cmd_q.size() == `HCI_CMD_DEPTH;
    exp[18]   = resp_q.size() == 0;
    exp[19]   = resp_q.size() == `HCI_RESP_DEPTH;
    csr_access(1'b0, `HCI_ADDR_QUEUE_STAT, '0, d, e);
    check_flag("status read error", e, 1'b0);
    check_csr_data("queue status", d, exp);
    csr_access(1'b0, `HCI_ADDR_RESET_CTRL, '0, d, e);
    check_flag("reset register read error", e, 1'b0);
    check_csr_data("reset register readback", d, '0);
  endtask

  task automatic reset_queues(logic rst_cmd, logic rst_resp);
    hci_pkg::csr_data_t d;
    logic e;
    csr_access(1'b1, `HCI_ADDR_RESET_CTRL, {29'h0, rst_resp, rst_cmd, 1'b0}, d, e);
    check_flag("reset write error", e, 1'b0);
    // Flush lands one edge after the ack
    @(posedge hclk_i);
    if (rst_cmd) begin
      cmd_q.delete();
      half_pending = 1'b0;
    end
    if (rst_resp) begin
      resp_q.delete();
    end
    @(negedge hclk_i);
    check_status();
  endtask

  task automatic unmapped_access(logic wr, hci_pkg::csr_addr_t addr);
    hci_pkg::csr_data_t d;
    logic e;
    csr_access(wr, addr, next_rand(), d, e);
    check_flag("unmapped access error", e, 1'b1);
    if (!wr) begin
      check_csr_data("unmapped read data", d, '0);
    end
    check_status();
  endtask

  // One controller cycle; the model applies what the next edge does
  task automatic ctrl_step(logic rready, logic wvalid, hci_pkg::resp_desc_t wdata);
    @(posedge hclk_i);
    cmd_rready_i  <= rready;
    resp_wvalid_i <= wvalid;
    resp_wdata_i  <= wdata;
    @(negedge hclk_i);
    check_status();
    if (rready && cmd_q.size() != 0) begin
      void'(cmd_q.pop_front());
    end
    if (wvalid && resp_q.size() < `HCI_RESP_DEPTH) begin
      resp_q.push_back(wdata);
    end
  endtask

  initial begin
    logic [31:0] r;
    lcg_state        = 32'h80bc3b7c;
    half_pending     = 1'b0;
    half_low         = '0;
    cmd_thld         = `HCI_THLD_RESET;
    resp_thld        = `HCI_THLD_RESET;
    rst_n_i         <= 1'b0;
    csr_req_i       <= 1'b0;
    csr_req_is_wr_i <= 1'b0;
    csr_addr_i      <= '0;
    csr_wr_data_i   <= '0;
    cmd_rready_i    <= 1'b0;
    resp_wvalid_i   <= 1'b0;
    resp_wdata_i    <= '0;
    repeat (10) @(posedge hclk_i);
    rst_n_i <= 1'b1;
    @(negedge hclk_i);
    check_flag("rd ack after reset", csr_rd_ack_o, 1'b0);
    check_flag("wr ack after reset", csr_wr_ack_o, 1'b0);
    check_flag("rd err after reset", csr_rd_err_o, 1'b0);
    check_flag("wr err after reset", csr_wr_err_o, 1'b0);
    check_status();
    read_stat();

    // Fill the command queue, the ninth descriptor is dropped
    repeat (2 * (`HCI_CMD_DEPTH + 1)) write_cmd_word(next_rand());
    ctrl_step(1'b1, 1'b0, '0);
    repeat (2) write_cmd_word(next_rand());
    repeat (12) ctrl_step(1'b1, 1'b0, '0);

    // Fill the response queue past full, then drain past empty
    repeat (`HCI_RESP_DEPTH + 2) ctrl_step(1'b0, 1'b1, next_rand());
    read_stat();
    repeat (`HCI_RESP_DEPTH + 1) read_resp();

    // Pending low half is discarded by a command queue reset
    write_cmd_word(next_rand());
    reset_queues(1'b1, 1'b0);
    repeat (2) write_cmd_word(next_rand());
    ctrl_step(1'b1, 1'b0, '0);

    unmapped_access(1'b0, 5'h14);
    unmapped_access(1'b0, `HCI_ADDR_CMD_PORT);
    unmapped_access(1'b1, 5'h14);
    unmapped_access(1'b1, `HCI_ADDR_QUEUE_STAT);

    for (int i = 0; i < NumOps; i++) begin
      r = next_rand();
      case (r[18:16])
        3'd0, 3'd1: write_cmd_word(next_rand());
        3'd2: read_resp();
        3'd3, 3'd4: ctrl_step(r[20] & r[21], r[22], next_rand());
        3'd5: write_read_thld(hci_pkg::thld_t'(r[27:24] % 10), hci_pkg::thld_t'(r[31:28] % 10));
        3'd6: read_stat();
        default: begin
          if (r[23:22] == 2'd0) begin
            reset_queues(r[24], r[25]);
          end else begin
            unmapped_access(r[26], r[27] ? 5'h14 : 5'h1C);
          end
        end
      endcase
    end

    $display("STATUS: PASS");
    $finish;
  end

endmodule
